/* include/grav_cfg.svh */
// #########################################################################
// build-time limits and number format of the integration sweep
// include wherever the widths, memory depth or dt shift are needed
// #########################################################################

`ifndef GRAV_CFG_SVH
`define GRAV_CFG_SVH

// signed fixed-point coordinate width
`define GRAV_COORD_W 32

// fraction bits of a coordinate, the datapath itself only shifts
`define GRAV_FRAC_W 16

// depth of the per-axis state memories
`define GRAV_MAX_BODIES 16

// dt = 2 ** -GRAV_DT_SHIFT
`define GRAV_DT_SHIFT 6

`endif

/* logic/grav_num_pkg.sv */
// #########################################################################
// numeric types of the integrator
// coordinates plus body index and body count widths
// #########################################################################

`default_nettype none

`include "grav_cfg.svh"

package grav_num_pkg;

	// position, velocity or acceleration component
	typedef logic signed [`GRAV_COORD_W-1:0] coord_t;

	// index into the state memories
	typedef logic [$clog2(`GRAV_MAX_BODIES)-1:0] body_idx_t;

	// number of active bodies, 1 up to GRAV_MAX_BODIES
	typedef logic [$clog2(`GRAV_MAX_BODIES+1)-1:0] body_cnt_t;

	// saturation limits
	localparam coord_t COORD_MAX = {1'b0, {(`GRAV_COORD_W-1){1'b1}}};
	localparam coord_t COORD_MIN = {1'b1, {(`GRAV_COORD_W-1){1'b0}}};

endpackage

`default_nettype wire

/* logic/grav_ctrl_pkg.sv */
// #########################################################################
// control-side types, the sweep states and the state field select
// shared by the sweep FSM, the state memory and the testbench
// #########################################################################

`default_nettype none

package grav_ctrl_pkg;

	// which field of a body a host access targets
	typedef logic [1:0] field_t;

	localparam field_t FIELD_POS = 2'd0;
	localparam field_t FIELD_VEL = 2'd1;
	localparam field_t FIELD_ACC = 2'd2;

	// one body costs the six states between IDLE and DONE
	typedef enum logic [2:0] {
		IDLE, RD_VEL, CALC_VEL, WR_VEL, RD_POS, CALC_POS, WR_POS, DONE
	} sweep_state_t;

endpackage

`default_nettype wire

/* logic/euler_lane.sv */
// #########################################################################
// one axis of the Euler update, result = old + rate * dt
// dt is a power of two so the product is an arithmetic shift
// sum saturates to the coordinate range, registered output
// #########################################################################

`default_nettype none

`include "grav_cfg.svh"

module euler_lane (
	input  wire logic                 CLK,
	input  wire logic                 RESET,
	input  wire grav_num_pkg::coord_t old_i,
	input  wire grav_num_pkg::coord_t rate_i,
	output grav_num_pkg::coord_t      result_o
);

	grav_num_pkg::coord_t            delta;
	logic signed [`GRAV_COORD_W:0]   sum;
	grav_num_pkg::coord_t            sat;

	assign delta = rate_i >>> `GRAV_DT_SHIFT;

	// one guard bit catches overflow
	assign sum = {old_i[`GRAV_COORD_W-1], old_i} + {delta[`GRAV_COORD_W-1], delta};

	always_comb
	begin
		if (sum[`GRAV_COORD_W] != sum[`GRAV_COORD_W-1])
			sat = sum[`GRAV_COORD_W] ? grav_num_pkg::COORD_MIN : grav_num_pkg::COORD_MAX;
		else
			sat = sum[`GRAV_COORD_W-1:0];
	end

	always_ff @(posedge CLK)
	begin
		if (RESET)
			result_o <= '0;
		else
			result_o <= sat;
	end

endmodule

`default_nettype wire

/* logic/body_counter.sv */
// #########################################################################
// body index for the integration sweep
// clear latches the active body count, advance steps to the next body
// #########################################################################

`default_nettype none

module body_counter (
	input  wire logic                     CLK,
	input  wire logic                     RESET,
	input  wire logic                     clear_i,
	input  wire logic                     advance_i,
	input  wire grav_num_pkg::body_cnt_t  body_num_i,
	output grav_num_pkg::body_idx_t       body_idx_o,
	output logic                          last_body_o
);

	grav_num_pkg::body_idx_t idx_q;
	grav_num_pkg::body_cnt_t num_q;

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			idx_q <= '0;
			num_q <= grav_num_pkg::body_cnt_t'(1);
		end
		else if (clear_i)
		begin
			idx_q <= '0;
			num_q <= body_num_i;
		end
		else if (advance_i)
			idx_q <= idx_q + 1'b1;
	end

	assign body_idx_o = idx_q;

	// count is one-based, index zero-based
	assign last_body_o = ({1'b0, idx_q} == num_q - 1'b1);

endmodule

`default_nettype wire

/* logic/body_state_ram.sv */
// #########################################################################
// position, velocity and acceleration storage for all bodies
// sweep port reads an old/rate pair and writes back the result
// host port loads and reads back single words, writes blocked while busy
// #########################################################################

`default_nettype none

`include "grav_cfg.svh"

module body_state_ram (
	input  wire logic                     CLK,
	input  wire logic                     RESET,
	input  wire grav_num_pkg::body_idx_t  body_idx_i,
	input  wire logic                     rd_en_i,
	input  wire logic                     wr_en_i,
	input  wire logic                     pos_phase_i,
	input  wire grav_num_pkg::coord_t     result_x_i,
	input  wire grav_num_pkg::coord_t     result_y_i,
	input  wire grav_num_pkg::coord_t     result_z_i,
	output grav_num_pkg::coord_t          old_x_o,
	output grav_num_pkg::coord_t          old_y_o,
	output grav_num_pkg::coord_t          old_z_o,
	output grav_num_pkg::coord_t          rate_x_o,
	output grav_num_pkg::coord_t          rate_y_o,
	output grav_num_pkg::coord_t          rate_z_o,
	input  wire logic                     busy_i,
	input  wire logic                     host_we_i,
	input  wire grav_ctrl_pkg::field_t    host_field_i,
	input  wire logic [1:0]               host_axis_i,
	input  wire grav_num_pkg::body_idx_t  host_body_i,
	input  wire grav_num_pkg::coord_t     host_wdata_i,
	input  wire grav_ctrl_pkg::field_t    host_rd_field_i,
	input  wire logic [1:0]               host_rd_axis_i,
	input  wire grav_num_pkg::body_idx_t  host_rd_body_i,
	output grav_num_pkg::coord_t          host_rdata_o
);

	grav_num_pkg::coord_t result [3];
	grav_num_pkg::coord_t sweep_word [3][3];
	grav_num_pkg::coord_t host_word [3][3];
	grav_num_pkg::coord_t old_q [3];
	grav_num_pkg::coord_t rate_q [3];
	grav_ctrl_pkg::field_t wr_field;
	grav_ctrl_pkg::field_t old_field;
	grav_ctrl_pkg::field_t rate_field;

	assign result[0] = result_x_i;
	assign result[1] = result_y_i;
	assign result[2] = result_z_i;

	// velocity phase: v += a*dt, position phase: p += v*dt
	assign wr_field   = pos_phase_i ? grav_ctrl_pkg::FIELD_POS : grav_ctrl_pkg::FIELD_VEL;
	assign old_field  = wr_field;
	assign rate_field = pos_phase_i ? grav_ctrl_pkg::FIELD_VEL : grav_ctrl_pkg::FIELD_ACC;

	// one array per field and axis
	for (genvar f = 0; f < 3; f++)
	begin : g_field
		for (genvar a = 0; a < 3; a++)
		begin : g_axis
			grav_num_pkg::coord_t mem [`GRAV_MAX_BODIES];
			logic sweep_we;
			logic host_we;

			assign sweep_we = wr_en_i && (wr_field == 2'(f));
			assign host_we  = host_we_i && !busy_i &&
				(host_field_i == 2'(f)) && (host_axis_i == 2'(a));

			always_ff @(posedge CLK)
			begin
				if (sweep_we)
					mem[body_idx_i] <= result[a];
				else if (host_we)
					mem[host_body_i] <= host_wdata_i;
			end

			assign sweep_word[f][a] = mem[body_idx_i];
			assign host_word[f][a]  = mem[host_rd_body_i];
		end
	end

	// registered sweep read, one cycle latency
	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			for (int a = 0; a < 3; a++)
			begin
				old_q[a]  <= '0;
				rate_q[a] <= '0;
			end
		end
		else if (rd_en_i)
		begin
			for (int a = 0; a < 3; a++)
			begin
				old_q[a]  <= sweep_word[old_field][a];
				rate_q[a] <= sweep_word[rate_field][a];
			end
		end
	end

	// host read, out of range selects return zero
	always_ff @(posedge CLK)
	begin
		if (RESET)
			host_rdata_o <= '0;
		else if (host_rd_field_i <= grav_ctrl_pkg::FIELD_ACC && host_rd_axis_i <= 2'd2)
			host_rdata_o <= host_word[host_rd_field_i][host_rd_axis_i];
		else
			host_rdata_o <= '0;
	end

	assign old_x_o  = old_q[0];
	assign old_y_o  = old_q[1];
	assign old_z_o  = old_q[2];
	assign rate_x_o = rate_q[0];
	assign rate_y_o = rate_q[1];
	assign rate_z_o = rate_q[2];

endmodule

`default_nettype wire

/* logic/integrate_fsm.sv */
// #########################################################################
// sequencer of the sweep, six states per body
// read, compute and write velocity, then the same for position
// four-phase req/ack with the host around each step
// #########################################################################

`default_nettype none

module integrate_fsm (
	input  wire logic CLK,
	input  wire logic RESET,
	input  wire logic step_req_i,
	input  wire logic last_body_i,
	output logic      cnt_clear_o,
	output logic      cnt_advance_o,
	output logic      rd_en_o,
	output logic      wr_en_o,
	output logic      pos_phase_o,
	output logic      step_ack_o,
	output logic      busy_o
);

	grav_ctrl_pkg::sweep_state_t state;
	grav_ctrl_pkg::sweep_state_t next_state;

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			state      <= grav_ctrl_pkg::IDLE;
			step_ack_o <= 1'b0;
		end
		else
		begin
			state <= next_state;
			// ack one cycle after DONE entry, drops with req
			step_ack_o <= (state == grav_ctrl_pkg::DONE) && step_req_i;
		end
	end

	always_comb
	begin
		next_state = state;
		unique case (state)
			grav_ctrl_pkg::IDLE:
			begin
				if (step_req_i)
					next_state = grav_ctrl_pkg::RD_VEL;
			end
			grav_ctrl_pkg::RD_VEL:
				next_state = grav_ctrl_pkg::CALC_VEL;
			grav_ctrl_pkg::CALC_VEL:
				next_state = grav_ctrl_pkg::WR_VEL;
			grav_ctrl_pkg::WR_VEL:
				next_state = grav_ctrl_pkg::RD_POS;
			grav_ctrl_pkg::RD_POS:
				next_state = grav_ctrl_pkg::CALC_POS;
			grav_ctrl_pkg::CALC_POS:
				next_state = grav_ctrl_pkg::WR_POS;
			grav_ctrl_pkg::WR_POS:
			begin
				if (last_body_i)
					next_state = grav_ctrl_pkg::DONE;
				else
					next_state = grav_ctrl_pkg::RD_VEL;
			end
			grav_ctrl_pkg::DONE:
			begin
				// hold until the host lets go of req
				if (!step_req_i)
					next_state = grav_ctrl_pkg::IDLE;
			end
			default:
				next_state = grav_ctrl_pkg::IDLE;
		endcase
	end

	// counter controls
	assign cnt_clear_o   = (state == grav_ctrl_pkg::IDLE) && step_req_i;
	assign cnt_advance_o = (state == grav_ctrl_pkg::WR_POS) && !last_body_i;

	// memory controls
	assign rd_en_o = (state == grav_ctrl_pkg::RD_VEL) || (state == grav_ctrl_pkg::RD_POS);
	assign wr_en_o = (state == grav_ctrl_pkg::WR_VEL) || (state == grav_ctrl_pkg::WR_POS);
	assign pos_phase_o = (state == grav_ctrl_pkg::RD_POS) ||
		(state == grav_ctrl_pkg::CALC_POS) || (state == grav_ctrl_pkg::WR_POS);

	assign busy_o = (state != grav_ctrl_pkg::IDLE) && (state != grav_ctrl_pkg::DONE);

endmodule

`default_nettype wire

/* logic/grav_step.sv */
// #########################################################################
// one semi-implicit Euler timestep over all active bodies
// host loads the state memory, pulses a step by req/ack, reads back
// three axis lanes share the sequencer, counter and memory
// #########################################################################

`default_nettype none

module grav_step (
	input  wire logic                     CLK,
	input  wire logic                     RESET,
	input  wire logic                     step_req_i,
	input  wire grav_num_pkg::body_cnt_t  body_num_i,
	output logic                          step_ack_o,
	output logic                          busy_o,
	input  wire logic                     host_we_i,
	input  wire grav_ctrl_pkg::field_t    host_field_i,
	input  wire logic [1:0]               host_axis_i,
	input  wire grav_num_pkg::body_idx_t  host_body_i,
	input  wire grav_num_pkg::coord_t     host_wdata_i,
	input  wire grav_ctrl_pkg::field_t    host_rd_field_i,
	input  wire logic [1:0]               host_rd_axis_i,
	input  wire grav_num_pkg::body_idx_t  host_rd_body_i,
	output grav_num_pkg::coord_t          host_rdata_o
);

	logic                    cnt_clear;
	logic                    cnt_advance;
	logic                    rd_en;
	logic                    wr_en;
	logic                    pos_phase;
	logic                    last_body;
	grav_num_pkg::body_idx_t body_idx;
	grav_num_pkg::coord_t    old_w [3];
	grav_num_pkg::coord_t    rate_w [3];
	grav_num_pkg::coord_t    result_w [3];

	integrate_fsm u_fsm (
		.CLK           (CLK),
		.RESET         (RESET),
		.step_req_i    (step_req_i),
		.last_body_i   (last_body),
		.cnt_clear_o   (cnt_clear),
		.cnt_advance_o (cnt_advance),
		.rd_en_o       (rd_en),
		.wr_en_o       (wr_en),
		.pos_phase_o   (pos_phase),
		.step_ack_o    (step_ack_o),
		.busy_o        (busy_o)
	);

	body_counter u_counter (
		.CLK         (CLK),
		.RESET       (RESET),
		.clear_i     (cnt_clear),
		.advance_i   (cnt_advance),
		.body_num_i  (body_num_i),
		.body_idx_o  (body_idx),
		.last_body_o (last_body)
	);

	body_state_ram u_ram (
		.CLK             (CLK),
		.RESET           (RESET),
		.body_idx_i      (body_idx),
		.rd_en_i         (rd_en),
		.wr_en_i         (wr_en),
		.pos_phase_i     (pos_phase),
		.result_x_i      (result_w[0]),
		.result_y_i      (result_w[1]),
		.result_z_i      (result_w[2]),
		.old_x_o         (old_w[0]),
		.old_y_o         (old_w[1]),
		.old_z_o         (old_w[2]),
		.rate_x_o        (rate_w[0]),
		.rate_y_o        (rate_w[1]),
		.rate_z_o        (rate_w[2]),
		.busy_i          (busy_o),
		.host_we_i       (host_we_i),
		.host_field_i    (host_field_i),
		.host_axis_i     (host_axis_i),
		.host_body_i     (host_body_i),
		.host_wdata_i    (host_wdata_i),
		.host_rd_field_i (host_rd_field_i),
		.host_rd_axis_i  (host_rd_axis_i),
		.host_rd_body_i  (host_rd_body_i),
		.host_rdata_o    (host_rdata_o)
	);

	// x, y, z lanes
	for (genvar a = 0; a < 3; a++)
	begin : g_lane
		euler_lane u_lane (
			.CLK      (CLK),
			.RESET    (RESET),
			.old_i    (old_w[a]),
			.rate_i   (rate_w[a]),
			.result_o (result_w[a])
		);
	end

endmodule

`default_nettype wire

/* dv/grav_step_asserts.sv */
// #########################################################################
// req/ack and busy properties of the step handshake
// bound into every grav_step instance
// #########################################################################

`default_nettype none

module grav_step_asserts (
	input  wire logic CLK,
	input  wire logic RESET,
	input  wire logic step_req_i,
	input  wire logic step_ack_i,
	input  wire logic busy_i
);

	int assert_errors = 0;

	// ack only answers a pending request
	ack_needs_req: assert property (@(posedge CLK) disable iff (RESET)
		$rose(step_ack_i) |-> $past(step_req_i))
	else
	begin
		$error("step ack rose while step req was low");
		assert_errors++;
	end

	// ack is held for as long as req is
	ack_held: assert property (@(posedge CLK) disable iff (RESET)
		(step_ack_i && step_req_i) |=> step_ack_i)
	else
	begin
		$error("step ack dropped while step req was still high");
		assert_errors++;
	end

	ack_not_busy: assert property (@(posedge CLK) disable iff (RESET)
		!(busy_i && step_ack_i))
	else
	begin
		$error("busy and step ack high in the same cycle");
		assert_errors++;
	end

	// return to zero one cycle after req is released
	ack_release: assert property (@(posedge CLK) disable iff (RESET)
		!step_req_i |=> !step_ack_i)
	else
	begin
		$error("step ack still high a cycle after step req went low");
		assert_errors++;
	end

endmodule

bind grav_step grav_step_asserts u_asserts (
	.CLK        (CLK),
	.RESET      (RESET),
	.step_req_i (step_req_i),
	.step_ack_i (step_ack_o),
	.busy_i     (busy_o)
);

`default_nettype wire

/* dv/grav_step_tb.sv */
// #########################################################################
// testbench of the integration step
// loads random and near-limit states, runs steps by req/ack, and
// compares every stored word and the ack latency with a local model
// #########################################################################

`default_nettype none

`include "grav_cfg.svh"

module grav_step_tb;

	localparam int NUM_STEPS      = 7;
	localparam int STEP_CYCLES    = 6 * `GRAV_MAX_BODIES + 40;
	localparam int ACCESS_CYCLES  = 2 * 9 * `GRAV_MAX_BODIES;
	localparam int TIMEOUT_CYCLES = NUM_STEPS * (STEP_CYCLES + ACCESS_CYCLES)
		+ 2 * ACCESS_CYCLES + 500;

	logic                     CLK;
	logic                     RESET;
	logic                     step_req;
	grav_num_pkg::body_cnt_t  body_num;
	logic                     step_ack;
	logic                     busy;
	logic                     host_we;
	grav_ctrl_pkg::field_t    host_field;
	logic [1:0]               host_axis;
	grav_num_pkg::body_idx_t  host_body;
	grav_num_pkg::coord_t     host_wdata;
	grav_ctrl_pkg::field_t    host_rd_field;
	logic [1:0]               host_rd_axis;
	grav_num_pkg::body_idx_t  host_rd_body;
	grav_num_pkg::coord_t     host_rdata;

	// field, axis, body
	grav_num_pkg::coord_t model_mem [3][3][`GRAV_MAX_BODIES];
	integer               seed;
	int                   err_cnt;
	int                   cycle_cnt;

	grav_step u_grav_step (
		.CLK             (CLK),
		.RESET           (RESET),
		.step_req_i      (step_req),
		.body_num_i      (body_num),
		.step_ack_o      (step_ack),
		.busy_o          (busy),
		.host_we_i       (host_we),
		.host_field_i    (host_field),
		.host_axis_i     (host_axis),
		.host_body_i     (host_body),
		.host_wdata_i    (host_wdata),
		.host_rd_field_i (host_rd_field),
		.host_rd_axis_i  (host_rd_axis),
		.host_rd_body_i  (host_rd_body),
		.host_rdata_o    (host_rdata)
	);

	always #4 CLK = ~CLK;

	// base + rate * dt, clamped to the signed coordinate range
	function automatic grav_num_pkg::coord_t sat_add(grav_num_pkg::coord_t base,
		grav_num_pkg::coord_t rate);
		longint hi;
		longint lo;
		longint total;
		hi    = (longint'(1) <<< (`GRAV_COORD_W - 1)) - 1;
		lo    = -(longint'(1) <<< (`GRAV_COORD_W - 1));
		total = longint'(base) + (longint'(rate) >>> `GRAV_DT_SHIFT);
		if (total > hi)
			total = hi;
		else if (total < lo)
			total = lo;
		return grav_num_pkg::coord_t'(total);
	endfunction

	// velocity first, then position from the new velocity
	task automatic model_step(input int n);
		for (int b = 0; b < n; b++)
		begin
			for (int a = 0; a < 3; a++)
			begin
				model_mem[grav_ctrl_pkg::FIELD_VEL][a][b] = sat_add(
					model_mem[grav_ctrl_pkg::FIELD_VEL][a][b],
					model_mem[grav_ctrl_pkg::FIELD_ACC][a][b]);
				model_mem[grav_ctrl_pkg::FIELD_POS][a][b] = sat_add(
					model_mem[grav_ctrl_pkg::FIELD_POS][a][b],
					model_mem[grav_ctrl_pkg::FIELD_VEL][a][b]);
			end
		end
	endtask

	task automatic host_write(input int field, input int axis, input int body,
		input grav_num_pkg::coord_t data);
		@(negedge CLK);
		host_we    = 1'b1;
		host_field = grav_ctrl_pkg::field_t'(field);
		host_axis  = 2'(axis);
		host_body  = grav_num_pkg::body_idx_t'(body);
		host_wdata = data;
		@(negedge CLK);
		host_we = 1'b0;
		model_mem[field][axis][body] = data;
	endtask

	// extreme mode puts every word within 4095 of a range limit
	task automatic load_state(input bit extreme);
		int                   rnd;
		grav_num_pkg::coord_t value;
		for (int b = 0; b < `GRAV_MAX_BODIES; b++)
		begin
			for (int f = 0; f < 3; f++)
			begin
				for (int a = 0; a < 3; a++)
				begin
					rnd = $random(seed);
					if (!extreme)
						value = rnd;
					else if (rnd[31])
						value = grav_num_pkg::COORD_MIN + grav_num_pkg::coord_t'(rnd & 'hfff);
					else
						value = grav_num_pkg::COORD_MAX - grav_num_pkg::coord_t'(rnd & 'hfff);
					host_write(f, a, b, value);
				end
			end
		end
	endtask

	// reads back every word, inactive bodies included
	task automatic check_state();
		for (int f = 0; f < 3; f++)
		begin
			for (int a = 0; a < 3; a++)
			begin
				for (int b = 0; b < `GRAV_MAX_BODIES; b++)
				begin
					@(negedge CLK);
					host_rd_field = grav_ctrl_pkg::field_t'(f);
					host_rd_axis  = 2'(a);
					host_rd_body  = grav_num_pkg::body_idx_t'(b);
					@(negedge CLK);
					if (host_rdata !== model_mem[f][a][b])
					begin
						err_cnt++;
						$display("[FAIL] %0t host_rdata_o field %0d axis %0d body %0d got %h exp %h",
							$time, f, a, b, host_rdata, model_mem[f][a][b]);
					end
				end
			end
		end
	endtask

	task automatic run_step(input int n);
		int edges;
		int hold;
		@(negedge CLK);
		body_num = grav_num_pkg::body_cnt_t'(n);
		step_req = 1'b1;
		@(posedge CLK);
		@(negedge CLK);
		edges = 0;
		if (busy !== 1'b1)
		begin
			err_cnt++;
			$display("[FAIL] %0t busy_o got %b exp 1", $time, busy);
		end
		while (step_ack !== 1'b1)
		begin
			@(negedge CLK);
			edges++;
		end
		if (edges != 6 * n + 1)
		begin
			err_cnt++;
			$display("[FAIL] %0t step_ack_o latency got %0d exp %0d", $time, edges, 6 * n + 1);
		end
		// keep req up a little longer, ack must stay
		hold = $unsigned($random(seed)) % 8;
		repeat (hold)
		begin
			@(negedge CLK);
			if (step_ack !== 1'b1)
			begin
				err_cnt++;
				$display("[FAIL] %0t step_ack_o got %b exp 1", $time, step_ack);
			end
		end
		step_req = 1'b0;
		@(negedge CLK);
		if (step_ack !== 1'b0)
		begin
			err_cnt++;
			$display("[FAIL] %0t step_ack_o got %b exp 0", $time, step_ack);
		end
		model_step(n);
	endtask

	initial
	begin : watchdog
		while (cycle_cnt < TIMEOUT_CYCLES)
		begin
			@(posedge CLK);
			cycle_cnt++;
		end
		$display("timeout, the test did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	initial
	begin : main
		int n;
		int total;
		seed          = 61;
		err_cnt       = 0;
		cycle_cnt     = 0;
		CLK           = 1'b0;
		RESET         = 1'b1;
		step_req      = 1'b0;
		body_num      = grav_num_pkg::body_cnt_t'(1);
		host_we       = 1'b0;
		host_field    = grav_ctrl_pkg::FIELD_POS;
		host_axis     = 2'd0;
		host_body     = '0;
		host_wdata    = '0;
		host_rd_field = grav_ctrl_pkg::FIELD_POS;
		host_rd_axis  = 2'd0;
		host_rd_body  = '0;
		repeat (10) @(posedge CLK);
		@(negedge CLK);
		RESET = 1'b0;

		// quiet handshake before any request
		repeat (3)
		begin
			@(negedge CLK);
			if (step_ack !== 1'b0 || busy !== 1'b0)
			begin
				err_cnt++;
				$display("[FAIL] %0t step_ack_o/busy_o got %b/%b exp 0/0", $time, step_ack, busy);
			end
		end

		// random states, back-to-back steps without reload
		load_state(1'b0);
		run_step(`GRAV_MAX_BODIES);
		check_state();
		for (int s = 0; s < 4; s++)
		begin
			n = 1 + ($unsigned($random(seed)) % `GRAV_MAX_BODIES);
			run_step(n);
			check_state();
		end

		// near the range limits, results clamp
		load_state(1'b1);
		n = 1 + ($unsigned($random(seed)) % `GRAV_MAX_BODIES);
		run_step(n);
		check_state();
		run_step(`GRAV_MAX_BODIES);
		check_state();

		total = err_cnt + u_grav_step.u_asserts.assert_errors;
		$display("checks failed: %0d, assertions failed: %0d", err_cnt,
			u_grav_step.u_asserts.assert_errors);
		if (total == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* grav_step.f */
+incdir+include
logic/grav_num_pkg.sv
logic/grav_ctrl_pkg.sv
logic/euler_lane.sv
logic/body_counter.sv
logic/body_state_ram.sv
logic/integrate_fsm.sv
logic/grav_step.sv
dv/grav_step_asserts.sv
dv/grav_step_tb.sv
